/* design/umi_defs.svh */
/*
 * UMI command path constants
 * Command word width and command FIFO depth
 */

`ifndef UMI_DEFS_SVH
`define UMI_DEFS_SVH

// --------------------------------------------------
// Command word
// --------------------------------------------------
`define UMI_CW 32            // Packed command word width

// --------------------------------------------------
// Buffering
// --------------------------------------------------
`define UMI_FIFO_DEPTH 4     // Words held between producer and consumer

`endif

/* design/umi_pkg.sv */
/*
 * UMI command types
 * Opcode encoding shared by the packer, the unpacker and the checker.
 * Requests carry bit 0 set and responses carry it clear.
 */

`default_nettype none

package umi_pkg;

   // --------------------------------------------------
   // Command opcodes (bits 4:0 of the command word)
   // --------------------------------------------------
   typedef enum logic [4:0] {
      UMI_INVALID    = 5'd0,  // Never forwarded
      UMI_REQ_READ   = 5'd1,
      UMI_RESP_READ  = 5'd2,  // Read data return
      UMI_REQ_WRITE  = 5'd3,
      UMI_RESP_WRITE = 5'd4,  // Write acknowledge
      UMI_REQ_POSTED = 5'd5,  // Write with no response
      UMI_REQ_RDMA   = 5'd7,
      UMI_REQ_ATOMIC = 5'd9   // Bits 15:8 hold the atomic type
   } umi_opcode_e;

   // Responses are even codes
   // The error field only has meaning on a response
   // Atomic requests reuse the length byte

endpackage

`default_nettype wire

/* design/umi_unpack.sv */
/*
 * UMI command unpacker
 * Splits a packed command word into its control fields.
 * Length is masked for atomics and error is masked off requests.
 */

`timescale 1ns/1ns
`default_nettype none

module umi_unpack
   import umi_pkg::*;
#(
   parameter int CW = 32
) (
   input  wire [CW-1:0] packet_cmd,
   output logic [4:0]   cmd_opcode,
   output logic [2:0]   cmd_size,
   output logic [7:0]   cmd_len,
   output logic [7:0]   cmd_atype,
   output logic [3:0]   cmd_qos,
   output logic [1:0]   cmd_prot,
   output logic         cmd_eom,
   output logic         cmd_eof,
   output logic         cmd_ex,
   output logic [1:0]   cmd_user,
   output logic [23:0]  cmd_user_extended,
   output logic [1:0]   cmd_err,
   output logic [4:0]   cmd_hostid
);

   logic is_resp;     // Response word
   logic is_atomic;   // Atomic request

   // --------------------------------------------------
   // Command class decode
   // --------------------------------------------------
   assign is_resp   = ~packet_cmd[0] & (packet_cmd[7:0] != 8'(UMI_INVALID));
   assign is_atomic = (packet_cmd[4:0] == UMI_REQ_ATOMIC);  // Full opcode match

   // Field split
   assign cmd_opcode        = packet_cmd[4:0];
   assign cmd_size          = packet_cmd[7:5];
   assign cmd_len           = is_atomic ? 8'd0 : packet_cmd[15:8];
   assign cmd_atype         = packet_cmd[15:8];    // Always passed through
   assign cmd_qos           = packet_cmd[19:16];
   assign cmd_prot          = packet_cmd[21:20];
   assign cmd_eom           = packet_cmd[22];
   assign cmd_eof           = packet_cmd[23];
   assign cmd_ex            = packet_cmd[24];
   assign cmd_user          = packet_cmd[26:25];
   assign cmd_err           = is_resp ? packet_cmd[26:25] : 2'd0;
   assign cmd_hostid        = packet_cmd[31:27];

   // Everything above the low byte
   assign cmd_user_extended = packet_cmd[31:8];

endmodule

`default_nettype wire

/* design/umi_pack.sv */
/*
 * UMI command producer
 * Packs the command fields into one word and registers it toward the
 * command FIFO. Invalid opcodes and commands that meet a full FIFO are
 * dropped and flagged with a one-cycle pulse.
 */

`timescale 1ns/1ns
`default_nettype none

`include "umi_defs.svh"

module umi_pack
   import umi_pkg::*;
(
   input  wire               clk,
   input  wire               rst_n,
   input  wire               cmd_in_valid,  // One-cycle command strobe
   input  wire umi_opcode_e  opcode,
   input  wire [2:0]         size,
   input  wire [7:0]         len_atype,     // Length or atomic type
   input  wire [3:0]         qos,
   input  wire [1:0]         prot,
   input  wire               eom,
   input  wire               eof,
   input  wire               ex,
   input  wire [1:0]         user_err,      // User bits or error bits
   input  wire [4:0]         hostid,
   input  wire               full,          // FIFO has no room after this edge
   output logic              wr_en,
   output logic [`UMI_CW-1:0] wr_data,
   output logic              drop_invalid,
   output logic              drop_full
);

   logic [`UMI_CW-1:0] cmd_word;
   logic               cmd_bad;    // Opcode is the invalid code

   // --------------------------------------------------
   // Field packing, low field first
   // --------------------------------------------------
   assign cmd_word = {hostid, user_err, ex, eof, eom, prot, qos, len_atype, size, opcode};
   assign cmd_bad  = (opcode == UMI_INVALID);

   // Strobes, invalid wins over full
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_en        <= 1'b0;
         drop_invalid <= 1'b0;
         drop_full    <= 1'b0;
      end else begin
         wr_en        <= cmd_in_valid & ~cmd_bad & ~full;
         drop_invalid <= cmd_in_valid & cmd_bad;
         drop_full    <= cmd_in_valid & ~cmd_bad & full;  // Overflow
      end
   end

   // Word register, only loaded on a strobe
   always_ff @(posedge clk) begin
      if (cmd_in_valid)
         wr_data <= cmd_word;
   end

endmodule

`default_nettype wire

/* design/umi_cmd_fifo.sv */
/*
 * Command FIFO
 * Circular buffer with first-word fall-through read port.
 * full looks one edge ahead so a producer with a registered write
 * never overruns the buffer.
 */

`timescale 1ns/1ns
`default_nettype none

module umi_cmd_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 4
) (
   input  wire              clk,
   input  wire              rst_n,
   input  wire              wr_en,
   input  wire [WIDTH-1:0]  wr_data,
   input  wire              rd_en,     // Advance the head
   output logic [WIDTH-1:0] rd_data,   // Head word
   output logic             full,
   output logic             empty
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width
   localparam int CNTW = $clog2(DEPTH + 1);              // Count width

   logic [WIDTH-1:0] mem [DEPTH];   // Storage, no reset
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [CNTW-1:0]  count;         // Words stored
   logic [CNTW-1:0]  count_next;
   logic             do_wr;
   logic             do_rd;

   // --------------------------------------------------
   // Access qualification
   // --------------------------------------------------
   assign do_rd = rd_en & ~empty;
   assign do_wr = wr_en & ((count != CNTW'(DEPTH)) | do_rd);  // Read frees a slot

   always_comb begin
      count_next = count;
      case ({do_wr, do_rd})
         2'b10:   count_next = count + 1'b1;
         2'b01:   count_next = count - 1'b1;
         default: count_next = count;   // Idle or read plus write
      endcase
   end

   assign empty   = (count == '0);
   assign full    = (count_next == CNTW'(DEPTH));  // Occupancy after this edge
   assign rd_data = mem[rd_ptr];

   // --------------------------------------------------
   // Pointers and count
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         count <= count_next;
         if (do_wr)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

endmodule

`default_nettype wire

/* design/umi_cmd_sink.sv */
/*
 * UMI command consumer
 * Pops the command FIFO while take is high, unpacks the head word
 * and registers the fields. out_valid marks each captured word.
 */

`timescale 1ns/1ns
`default_nettype none

`include "umi_defs.svh"

module umi_cmd_sink (
   input  wire               clk,
   input  wire               rst_n,
   input  wire               take,       // Consumer ready level
   input  wire               empty,
   input  wire [`UMI_CW-1:0] rd_data,    // FIFO head
   output logic              rd_en,
   output logic              out_valid,
   output logic [4:0]        opcode,
   output logic [2:0]        size,
   output logic [7:0]        len,
   output logic [7:0]        atype,
   output logic [3:0]        qos,
   output logic [1:0]        prot,
   output logic              eom,
   output logic              eof,
   output logic              ex,
   output logic [1:0]        user,
   output logic [23:0]       user_extended,
   output logic [1:0]        err,
   output logic [4:0]        hostid
);

   typedef enum logic {SINK_IDLE, SINK_HOLD} sink_state_e;

   sink_state_e state;   // HOLD for the cycle after a pop
   logic [4:0]  u_opcode;
   logic [2:0]  u_size;
   logic [7:0]  u_len, u_atype;
   logic [3:0]  u_qos;
   logic [1:0]  u_prot, u_user, u_err;
   logic        u_eom, u_eof, u_ex;
   logic [23:0] u_user_ext;
   logic [4:0]  u_hostid;

   assign rd_en = take & ~empty;   // Pop at the next edge

   umi_unpack #(.CW(`UMI_CW)) i_umi_unpack (
      .packet_cmd(rd_data), .cmd_opcode(u_opcode), .cmd_size(u_size), .cmd_len(u_len),
      .cmd_atype(u_atype), .cmd_qos(u_qos), .cmd_prot(u_prot), .cmd_eom(u_eom),
      .cmd_eof(u_eof), .cmd_ex(u_ex), .cmd_user(u_user), .cmd_user_extended(u_user_ext),
      .cmd_err(u_err), .cmd_hostid(u_hostid)
   );

   // --------------------------------------------------
   // Capture state, fields hold between pops
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) state <= SINK_IDLE;
      else        state <= rd_en ? SINK_HOLD : SINK_IDLE;
   end

   assign out_valid = (state == SINK_HOLD);

   always_ff @(posedge clk) begin
      if (rd_en) begin
         {opcode, size, len, atype}   <= {u_opcode, u_size, u_len, u_atype};
         {qos, prot, eom, eof, ex}    <= {u_qos, u_prot, u_eom, u_eof, u_ex};
         {user, user_extended}        <= {u_user, u_user_ext};
         {err, hostid}                <= {u_err, u_hostid};
      end
   end

endmodule

`default_nettype wire

/* design/umi_cmd_path.sv */
/*
 * UMI command path top level
 * Producer packs commands into a FIFO and the consumer
 * pops, unpacks and registers them in input order.
 */

`timescale 1ns/1ns
`default_nettype none

`include "umi_defs.svh"

module umi_cmd_path
   import umi_pkg::*;
(
   input  wire               clk,
   input  wire               rst_n,
   // Command input
   input  wire               cmd_in_valid,
   input  wire umi_opcode_e  opcode,
   input  wire [2:0]         size,
   input  wire [7:0]         len_atype,
   input  wire [3:0]         qos,
   input  wire [1:0]         prot,
   input  wire               eom,
   input  wire               eof,
   input  wire               ex,
   input  wire [1:0]         user_err,
   input  wire [4:0]         hostid,
   output wire               drop_invalid,
   output wire               drop_full,
   // Delivered command
   input  wire               take,
   output wire               out_valid,
   output wire [4:0]         cmd_opcode,
   output wire [2:0]         cmd_size,
   output wire [7:0]         cmd_len,
   output wire [7:0]         cmd_atype,
   output wire [3:0]         cmd_qos,
   output wire [1:0]         cmd_prot,
   output wire               cmd_eom,
   output wire               cmd_eof,
   output wire               cmd_ex,
   output wire [1:0]         cmd_user,
   output wire [23:0]        cmd_user_extended,
   output wire [1:0]         cmd_err,
   output wire [4:0]         cmd_hostid
);

   // --------------------------------------------------
   // Internal links
   // --------------------------------------------------
   wire               wr_en;
   wire [`UMI_CW-1:0] wr_data;
   wire               full;
   wire               rd_en;
   wire [`UMI_CW-1:0] rd_data;
   wire               empty;

   umi_pack i_umi_pack (
      .clk(clk), .rst_n(rst_n), .cmd_in_valid(cmd_in_valid), .opcode(opcode),
      .size(size), .len_atype(len_atype), .qos(qos), .prot(prot), .eom(eom),
      .eof(eof), .ex(ex), .user_err(user_err), .hostid(hostid), .full(full),
      .wr_en(wr_en), .wr_data(wr_data), .drop_invalid(drop_invalid), .drop_full(drop_full)
   );

   umi_cmd_fifo #(.WIDTH(`UMI_CW), .DEPTH(`UMI_FIFO_DEPTH)) i_umi_cmd_fifo (
      .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_data(wr_data), .rd_en(rd_en),
      .rd_data(rd_data), .full(full), .empty(empty)
   );

   umi_cmd_sink i_umi_cmd_sink (
      .clk(clk), .rst_n(rst_n), .take(take), .empty(empty), .rd_data(rd_data),
      .rd_en(rd_en), .out_valid(out_valid), .opcode(cmd_opcode), .size(cmd_size),
      .len(cmd_len), .atype(cmd_atype), .qos(cmd_qos), .prot(cmd_prot), .eom(cmd_eom),
      .eof(cmd_eof), .ex(cmd_ex), .user(cmd_user), .user_extended(cmd_user_extended),
      .err(cmd_err), .hostid(cmd_hostid)
   );

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
/*
 * Testbench clock source
 * Free-running clock, low at time zero, 40 ns period by default
 */

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD = 40   // ns
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD / 2) clk = ~clk;   // Half period per toggle

endmodule

`default_nettype wire

/* verification/tb_umi_cmd_path.sv */
/*
 * UMI command path testbench
 * Applies a table of commands with random fields, models the FIFO
 * occupancy to predict drops and delivery, and compares every
 * delivered field with the layout rules of the command word.
 */

`timescale 1ns/1ns
`default_nettype none

`include "umi_defs.svh"

module tb_umi_cmd_path
   import umi_pkg::*;
();

   typedef struct packed {
      umi_opcode_e op;
      logic        take;      // Consumer level while the row runs
      logic [3:0]  pause;     // Idle cycles after the strobe
      logic [1:0]  outcome;   // Delivered, invalid drop or full drop
   } row_t;

   localparam int NROWS = 19;
   localparam logic [1:0] DLV = 2'd0;
   localparam logic [1:0] INV = 2'd1;
   localparam logic [1:0] FUL = 2'd2;

   wire                clk;
   logic               rst_n;
   logic               cmd_in_valid;
   umi_opcode_e        opcode;
   logic [2:0]         size;
   logic [7:0]         len_atype;
   logic [3:0]         qos;
   logic [1:0]         prot;
   logic               eom;
   logic               eof;
   logic               ex;
   logic [1:0]         user_err;
   logic [4:0]         hostid;
   logic               take;
   wire                drop_invalid;
   wire                drop_full;
   wire                out_valid;
   wire [4:0]          cmd_opcode;
   wire [2:0]          cmd_size;
   wire [7:0]          cmd_len;
   wire [7:0]          cmd_atype;
   wire [3:0]          cmd_qos;
   wire [1:0]          cmd_prot;
   wire                cmd_eom;
   wire                cmd_eof;
   wire                cmd_ex;
   wire [1:0]          cmd_user;
   wire [23:0]         cmd_user_extended;
   wire [1:0]          cmd_err;
   wire [4:0]          cmd_hostid;

   row_t               tbl [NROWS];
   logic [`UMI_CW-1:0] exp_q [$];        // Accepted words not yet delivered
   logic [`UMI_CW-1:0] head;
   int                 row_idx = 0;      // Row behind the driven strobe
   int                 m_count = 0;      // Modeled FIFO occupancy
   int                 m_occ;            // Occupancy after the current edge
   logic [1:0]         m_out;
   logic               m_wr = 1'b0;      // Accepted word still on its way in
   logic               p_inv = 1'b0;     // Predicted pulses after the edge
   logic               p_full = 1'b0;
   logic               p_ov = 1'b0;
   int                 mismatches = 0;
   int                 failures = 0;
   int                 cycles = 0;
   int                 cycle_limit = 0;

   tb_clk_gen #(.PERIOD(40)) i_tb_clk_gen (.clk(clk));

   umi_cmd_path i_umi_cmd_path (
      .clk(clk), .rst_n(rst_n), .cmd_in_valid(cmd_in_valid), .opcode(opcode),
      .size(size), .len_atype(len_atype), .qos(qos), .prot(prot), .eom(eom),
      .eof(eof), .ex(ex), .user_err(user_err), .hostid(hostid),
      .drop_invalid(drop_invalid), .drop_full(drop_full), .take(take),
      .out_valid(out_valid), .cmd_opcode(cmd_opcode), .cmd_size(cmd_size),
      .cmd_len(cmd_len), .cmd_atype(cmd_atype), .cmd_qos(cmd_qos), .cmd_prot(cmd_prot),
      .cmd_eom(cmd_eom), .cmd_eof(cmd_eof), .cmd_ex(cmd_ex), .cmd_user(cmd_user),
      .cmd_user_extended(cmd_user_extended), .cmd_err(cmd_err), .cmd_hostid(cmd_hostid)
   );

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         mismatches++;
         $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                  $time, name, exp, got);
      end
   endtask

   // Command word built from the field layout
   function automatic logic [`UMI_CW-1:0] pack_command();
      logic [`UMI_CW-1:0] w;
      w        = '0;
      w[4:0]   = opcode;
      w[7:5]   = size;
      w[15:8]  = len_atype;   // Length or atomic type
      w[19:16] = qos;
      w[21:20] = prot;
      w[22]    = eom;
      w[23]    = eof;
      w[24]    = ex;
      w[26:25] = user_err;
      w[31:27] = hostid;
      return w;
   endfunction

   task automatic check_delivered(input logic [`UMI_CW-1:0] w);
      logic resp;
      resp = ~w[0] && (w[4:0] != UMI_INVALID);   // Even opcode is a response
      check_field("cmd_opcode", cmd_opcode, w[4:0]);
      check_field("cmd_size", cmd_size, w[7:5]);
      check_field("cmd_len", cmd_len, (w[4:0] == UMI_REQ_ATOMIC) ? 8'd0 : w[15:8]);
      check_field("cmd_atype", cmd_atype, w[15:8]);
      check_field("cmd_qos", cmd_qos, w[19:16]);
      check_field("cmd_prot", cmd_prot, w[21:20]);
      check_field("cmd_eom", cmd_eom, w[22]);
      check_field("cmd_eof", cmd_eof, w[23]);
      check_field("cmd_ex", cmd_ex, w[24]);
      check_field("cmd_user", cmd_user, w[26:25]);
      check_field("cmd_user_extended", cmd_user_extended, w[31:8]);
      check_field("cmd_err", cmd_err, resp ? w[26:25] : 2'd0);
      check_field("cmd_hostid", cmd_hostid, w[31:27]);
   endtask

   // One strobe with random fields, then the row's idle cycles
   task automatic drive_row(input int i);
      logic [31:0] rnd;
      rnd = $urandom;
      @(posedge clk);
      cmd_in_valid <= 1'b1;
      row_idx      <= i;
      opcode       <= tbl[i].op;
      take         <= tbl[i].take;
      size         <= rnd[2:0];
      len_atype    <= rnd[10:3];
      qos          <= rnd[14:11];
      prot         <= rnd[16:15];
      eom          <= rnd[17];
      eof          <= rnd[18];
      ex           <= rnd[19];
      user_err     <= rnd[21:20];
      hostid       <= rnd[26:22];
      repeat (tbl[i].pause) begin
         @(posedge clk);
         cmd_in_valid <= 1'b0;
      end
   endtask

   // --------------------------------------------------
   // Occupancy model, pre-edge inputs
   // --------------------------------------------------
   always @(posedge clk) begin
      if (!rst_n) begin
         m_count = 0;
         m_wr    = 1'b0;
         p_inv   = 1'b0;
         p_full  = 1'b0;
         p_ov    = 1'b0;
      end else begin
         p_ov  = take && (m_count > 0);      // Pop at this edge
         m_occ = m_count + m_wr - p_ov;      // In-flight write lands now
         m_out = DLV;
         if (cmd_in_valid) begin
            if (opcode == UMI_INVALID)
               m_out = INV;                  // Invalid wins over full
            else if (m_occ == `UMI_FIFO_DEPTH)
               m_out = FUL;
            else
               exp_q.push_back(pack_command());
            assert (m_out == tbl[row_idx].outcome) else begin
               failures++;
               $display("Row %0d gives outcome %0d in the model, table expects %0d",
                        row_idx, m_out, tbl[row_idx].outcome);
            end
         end
         p_inv   = cmd_in_valid && (m_out == INV);
         p_full  = cmd_in_valid && (m_out == FUL);
         m_wr    = cmd_in_valid && (m_out == DLV);
         m_count = m_occ;
      end
   end

   // Output checks where everything is settled
   always @(negedge clk) begin
      if (cycles > 0) begin   // No clock edge has reset the DUT before this
         check_field("drop_invalid", drop_invalid, p_inv);
         check_field("drop_full", drop_full, p_full);
         check_field("out_valid", out_valid, p_ov);
         if (out_valid) begin
            assert (exp_q.size() > 0) else begin
               failures++;
               $display("Time %0t: a command came out that was never accepted", $time);
            end
            if (exp_q.size() > 0) begin
               head = exp_q.pop_front();
               check_delivered(head);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         failures++;
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------
   initial begin
      int total;
      void'($urandom(48743));
      rst_n        = 1'b0;
      cmd_in_valid = 1'b0;
      opcode       = UMI_INVALID;
      {size, len_atype, qos, prot, eom, eof, ex, user_err, hostid} = '0;
      take         = 1'b0;
      tbl = '{
         '{UMI_REQ_READ,   1'b1, 4'd1, DLV},
         '{UMI_RESP_READ,  1'b1, 4'd0, DLV},
         '{UMI_REQ_WRITE,  1'b1, 4'd0, DLV},
         '{UMI_INVALID,    1'b1, 4'd0, INV},
         '{UMI_RESP_WRITE, 1'b1, 4'd2, DLV},
         '{UMI_REQ_POSTED, 1'b1, 4'd0, DLV},
         '{UMI_REQ_RDMA,   1'b1, 4'd0, DLV},
         '{UMI_REQ_ATOMIC, 1'b1, 4'd0, DLV},
         '{UMI_INVALID,    1'b1, 4'd0, INV},
         '{UMI_RESP_READ,  1'b1, 4'd0, DLV},
         '{UMI_REQ_ATOMIC, 1'b1, 4'd4, DLV},   // Drain before the burst
         '{UMI_REQ_WRITE,  1'b0, 4'd0, DLV},   // Burst with take low
         '{UMI_RESP_READ,  1'b0, 4'd0, DLV},
         '{UMI_INVALID,    1'b0, 4'd0, INV},
         '{UMI_REQ_ATOMIC, 1'b0, 4'd0, DLV},
         '{UMI_REQ_READ,   1'b0, 4'd0, DLV},   // FIFO now holds its depth
         '{UMI_RESP_WRITE, 1'b0, 4'd0, FUL},
         '{UMI_REQ_POSTED, 1'b0, 4'd3, FUL},
         '{UMI_REQ_RDMA,   1'b1, 4'd6, DLV}    // Release take
      };
      total = 0;
      foreach (tbl[i])
         total += 1 + tbl[i].pause;
      cycle_limit = 10 * total + 100;

      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < NROWS; i++)
         drive_row(i);
      @(posedge clk);
      cmd_in_valid <= 1'b0;
      take         <= 1'b1;

      // Wait until every accepted command is out
      while (exp_q.size() != 0 || m_count != 0 || m_wr)
         @(negedge clk);
      repeat (3) @(negedge clk);

      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* umi_cmd_path.f */
+incdir+design
design/umi_pkg.sv
design/umi_unpack.sv
design/umi_pack.sv
design/umi_cmd_fifo.sv
design/umi_cmd_sink.sv
design/umi_cmd_path.sv
verification/tb_clk_gen.sv
verification/tb_umi_cmd_path.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UMI command path testbench with Verilator

LOG=sim.log
OBJ=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f umi_cmd_path.f --top-module tb_umi_cmd_path --Mdir "$OBJ"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/Vtb_umi_cmd_path" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
   exit 1
fi
exit 0
